/* hdl/rx_params.svh */
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// sample widths
`define RX_ADC_W        14
`define RX_GAIN_W       16
`define RX_ACC_W        38   // 30-bit product plus 8 bits of rate growth
`define RX_OUT_W        16
`define RX_FIFO_DEPTH   8

// settings bus map
`define RX_SET_BASE     160
`define RX_REG_GAIN     0
`define RX_REG_RATE     1
`define RX_REG_SHIFT    2
`define RX_REG_MUX      3
`define RX_REG_GPIO     4

`endif

/* hdl/rx_pkg.sv */
`default_nettype none

`include "rx_params.svh"

package rx_pkg;

   // control record with one field group per settings register
   typedef struct packed {
      logic signed [`RX_GAIN_W-1:0] gain_i;
      logic signed [`RX_GAIN_W-1:0] gain_q;
      logic [7:0]                   rate;      // 0 behaves as 1
      logic [5:0]                   shift;
      logic [1:0]                   mux_i;     // 0 = A, 1 = B, else zero
      logic [1:0]                   mux_q;
      logic [1:0]                   gpio_ena;  // bit 0 for I, bit 1 for Q
   } rx_ctrl_t;

   // one decimated sample before rounding
   typedef struct packed {
      logic signed [`RX_ACC_W-1:0] acc_i;
      logic signed [`RX_ACC_W-1:0] acc_q;
   } acc_pair_t;

   // output component range after saturation
   localparam int RX_OUT_MAX = 2 ** (`RX_OUT_W - 1) - 1;
   localparam int RX_OUT_MIN = -(2 ** (`RX_OUT_W - 1));

endpackage

`default_nettype wire

/* hdl/rx_stream_if.sv */
`timescale 1ns/100ps
`default_nettype none

// valid/ready link between blocks with a transfer when both are high
interface rx_stream_if #(
   parameter type T_PAYLOAD = logic
);

   logic     valid;
   logic     ready;
   T_PAYLOAD data;   // held while valid and not ready
   logic     flush;  // high while the core is stopped

   modport src (
      output valid,
      output data,
      output flush,
      input  ready
   );

   modport snk (
      input  valid,
      input  data,
      input  flush,
      output ready
   );

endinterface

`default_nettype wire

/* hdl/rx_settings.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module rx_settings
   import rx_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        i_set_stb,
   input  wire logic [7:0]  i_set_addr,
   input  wire logic [31:0] i_set_data,
   output rx_ctrl_t         o_ctrl
);

   localparam logic [7:0] ADDR_GAIN  = 8'(`RX_SET_BASE + `RX_REG_GAIN);
   localparam logic [7:0] ADDR_RATE  = 8'(`RX_SET_BASE + `RX_REG_RATE);
   localparam logic [7:0] ADDR_SHIFT = 8'(`RX_SET_BASE + `RX_REG_SHIFT);
   localparam logic [7:0] ADDR_MUX   = 8'(`RX_SET_BASE + `RX_REG_MUX);
   localparam logic [7:0] ADDR_GPIO  = 8'(`RX_SET_BASE + `RX_REG_GPIO);

   // a write lands on the edge after its strobe cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         o_ctrl <= '0;
      else if (i_set_stb)
      begin
         case (i_set_addr)
            ADDR_GAIN:
            begin
               o_ctrl.gain_i <= i_set_data[31:16];
               o_ctrl.gain_q <= i_set_data[15:0];
            end
            ADDR_RATE:  o_ctrl.rate     <= i_set_data[7:0];
            ADDR_SHIFT: o_ctrl.shift    <= i_set_data[5:0];
            ADDR_MUX:
            begin
               o_ctrl.mux_i <= i_set_data[1:0];
               o_ctrl.mux_q <= i_set_data[3:2];
            end
            ADDR_GPIO:  o_ctrl.gpio_ena <= i_set_data[1:0];
            default:    ;  // not ours
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/rx_decimator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module rx_decimator
   import rx_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 i_run,
   input  wire rx_ctrl_t             i_ctrl,
   input  wire logic [`RX_ADC_W-1:0] i_adc_a,
   input  wire logic [`RX_ADC_W-1:0] i_adc_b,
   output logic                      o_overflow,
   rx_stream_if.src                  m_out
);

   localparam int ACC_W  = `RX_ACC_W;
   localparam int PROD_W = `RX_ADC_W + `RX_GAIN_W;

   logic signed [`RX_ADC_W-1:0] adc_i, adc_q;
   logic signed [PROD_W-1:0]    prod_i, prod_q;
   logic signed [ACC_W-1:0]     ext_i, ext_q;
   logic signed [ACC_W-1:0]     acc_i, acc_q;
   logic                        v_mux, v_prod;
   logic [7:0]                  cnt;
   logic [7:0]                  rate_m1;
   logic                        dump;      // group complete and sum ready in acc
   logic                        take_sum;
   logic                        out_valid;
   acc_pair_t                   out_pair;

   assign rate_m1 = (i_ctrl.rate == 8'd0) ? 8'd0 : i_ctrl.rate - 8'd1;
   assign ext_i = {{(ACC_W - PROD_W){prod_i[PROD_W-1]}}, prod_i};
   assign ext_q = {{(ACC_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

   // channel select and scaling in two register stages
   always_ff @(posedge clk)
   begin
      case (i_ctrl.mux_i)
         2'd0:    adc_i <= i_adc_a;
         2'd1:    adc_i <= i_adc_b;
         default: adc_i <= '0;
      endcase
      case (i_ctrl.mux_q)
         2'd0:    adc_q <= i_adc_a;
         2'd1:    adc_q <= i_adc_b;
         default: adc_q <= '0;
      endcase
      prod_i <= adc_i * $signed(i_ctrl.gain_i);
      prod_q <= adc_q * $signed(i_ctrl.gain_q);
   end

   // integrate and dump with the next group starting as the sum is handed on
   always_ff @(posedge clk)
   begin
      if (rst || !i_run)
      begin
         v_mux  <= 1'b0;
         v_prod <= 1'b0;
         cnt    <= '0;
         dump   <= 1'b0;
         acc_i  <= '0;
         acc_q  <= '0;
      end
      else
      begin
         v_mux  <= 1'b1;
         v_prod <= v_mux;
         dump   <= 1'b0;
         if (v_prod)
         begin
            acc_i <= dump ? ext_i : acc_i + ext_i;
            acc_q <= dump ? ext_q : acc_q + ext_q;
            if (cnt >= rate_m1)  // also catches a rate lowered mid-group
            begin
               cnt  <= '0;
               dump <= 1'b1;
            end
            else
               cnt <= cnt + 8'd1;
         end
      end
   end

   // hold slot where a new sum is lost while the old one is still stuck
   assign take_sum = dump && (!out_valid || m_out.ready);

   always_ff @(posedge clk)
   begin
      if (rst || !i_run)
      begin
         out_valid  <= 1'b0;
         o_overflow <= 1'b0;
      end
      else
      begin
         if (take_sum)
            out_valid <= 1'b1;
         else if (m_out.ready)
            out_valid <= 1'b0;
         if (dump && !take_sum)
            o_overflow <= 1'b1;  // sticky until run drops
      end
   end

   always_ff @(posedge clk)
      if (take_sum)
         out_pair <= '{acc_i: acc_i, acc_q: acc_q};

   assign m_out.valid = out_valid;
   assign m_out.data  = out_pair;
   assign m_out.flush = !i_run;

endmodule

`default_nettype wire

/* hdl/sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module sample_fifo #(
   parameter type T_PAYLOAD = logic,
   parameter int  DEPTH     = `RX_FIFO_DEPTH   // power of two
) (
   input  wire logic clk,
   input  wire logic rst,
   rx_stream_if.snk  s_in,
   rx_stream_if.src  m_out
);

   localparam int AW = $clog2(DEPTH);

   T_PAYLOAD      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_wr;
   logic          do_rd;

   // only back-pressure when full
   assign s_in.ready = (count != (AW + 1)'(DEPTH));
   assign do_wr      = s_in.valid && s_in.ready && !s_in.flush;

   assign m_out.valid = (count != '0);
   assign m_out.data  = mem[rd_ptr];
   assign m_out.flush = s_in.flush;  // packer drops its word too
   assign do_rd       = m_out.valid && m_out.ready;

   always_ff @(posedge clk)
      if (do_wr)
         mem[wr_ptr] <= s_in.data;

   always_ff @(posedge clk)
   begin
      if (rst || s_in.flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/sample_packer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module sample_packer
   import rx_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire rx_ctrl_t              i_ctrl,
   input  wire logic [15:0]           i_io_rx,
   input  wire logic                  i_ready,
   rx_stream_if.snk                   s_in,
   output logic [2*`RX_OUT_W-1:0]     o_sample,
   output logic                       o_valid
);

   localparam int OUT_W = `RX_OUT_W;
   localparam int ACC_W = `RX_ACC_W;
   localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(RX_OUT_MAX);
   localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(RX_OUT_MIN);

   logic                    take;
   logic signed [OUT_W-1:0] i_out;
   logic signed [OUT_W-1:0] q_out;

   // arithmetic shift, round half up on the dropped bit, clamp to 16 bits
   function automatic logic signed [OUT_W-1:0] round_sat(
      input logic signed [ACC_W-1:0] v,
      input logic [5:0]              sh
   );
      logic signed [ACC_W-1:0] pre;
      logic signed [ACC_W-1:0] rnd;
      pre = v >>> (sh - 6'd1);  // keeps one extra bit for rounding
      if (sh == 6'd0)
         rnd = v;
      else
         rnd = (pre >>> 1) + $signed({{(ACC_W - 1){1'b0}}, pre[0]});
      if (rnd > SAT_MAX)
         return SAT_MAX[OUT_W-1:0];
      else if (rnd < SAT_MIN)
         return SAT_MIN[OUT_W-1:0];
      return rnd[OUT_W-1:0];
   endfunction

   assign i_out = round_sat(s_in.data.acc_i, i_ctrl.shift);
   assign q_out = round_sat(s_in.data.acc_q, i_ctrl.shift);

   assign s_in.ready = !o_valid || i_ready;  // empty or emptying now
   assign take       = s_in.valid && s_in.ready && !s_in.flush;

   // streaming gpio replaces the component LSBs
   always_ff @(posedge clk)
      if (take)
         o_sample <= {i_out[OUT_W-1:1], i_ctrl.gpio_ena[0] ? i_io_rx[15] : i_out[0],
                      q_out[OUT_W-1:1], i_ctrl.gpio_ena[1] ? i_io_rx[14] : q_out[0]};

   always_ff @(posedge clk)
   begin
      if (rst || s_in.flush)
         o_valid <= 1'b0;
      else if (take)
         o_valid <= 1'b1;
      else if (i_ready)
         o_valid <= 1'b0;
   end

endmodule

`default_nettype wire

/* hdl/rx_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module rx_core
   import rx_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rst,

   // settings bus
   input  wire logic                 i_set_stb,
   input  wire logic [7:0]           i_set_addr,
   input  wire logic [31:0]          i_set_data,

   input  wire logic [`RX_ADC_W-1:0] i_adc_a,
   input  wire logic [`RX_ADC_W-1:0] i_adc_b,
   input  wire logic [15:0]          i_io_rx,
   input  wire logic                 i_run,

   // output stream
   output logic [31:0]               o_sample,
   output logic                      o_valid,
   input  wire logic                 i_ready,
   output logic                      o_overflow
);

   rx_ctrl_t ctrl;

   rx_stream_if #(.T_PAYLOAD(acc_pair_t)) dec_fifo ();
   rx_stream_if #(.T_PAYLOAD(acc_pair_t)) fifo_pack ();

   rx_settings settings_inst (
      .clk        (clk),
      .rst        (rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_ctrl     (ctrl)
   );

   rx_decimator decimator_inst (
      .clk        (clk),
      .rst        (rst),
      .i_run      (i_run),
      .i_ctrl     (ctrl),
      .i_adc_a    (i_adc_a),
      .i_adc_b    (i_adc_b),
      .o_overflow (o_overflow),
      .m_out      (dec_fifo.src)
   );

   // absorbs short back-pressure between decimator and packer
   sample_fifo #(
      .T_PAYLOAD (acc_pair_t),
      .DEPTH     (`RX_FIFO_DEPTH)
   ) fifo_inst (
      .clk   (clk),
      .rst   (rst),
      .s_in  (dec_fifo.snk),
      .m_out (fifo_pack.src)
   );

   sample_packer packer_inst (
      .clk      (clk),
      .rst      (rst),
      .i_ctrl   (ctrl),
      .i_io_rx  (i_io_rx),
      .i_ready  (i_ready),
      .s_in     (fifo_pack.snk),
      .o_sample (o_sample),
      .o_valid  (o_valid)
   );

endmodule

`default_nettype wire

/* tests/rx_core_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_core_sva (
   input wire logic        clk,
   input wire logic        rst,
   input wire logic        i_run,
   input wire logic        i_ready,
   input wire logic        o_valid,
   input wire logic        o_overflow,
   input wire logic [31:0] o_sample
);

   a_reset_quiet : assert property (@(posedge clk) rst |=> !o_valid && !o_overflow)
      else $error("valid or overflow high while in reset");

   // word must not move under back-pressure
   a_hold : assert property (@(posedge clk) disable iff (rst)
      o_valid && !i_ready |=> $stable(o_sample))
      else $error("output word changed while stalled");

   a_sticky : assert property (@(posedge clk) disable iff (rst)
      o_overflow && i_run |=> o_overflow)
      else $error("overflow flag fell while running");

endmodule

bind rx_core rx_core_sva sva_inst (.*);

`default_nettype wire

/* tests/rx_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rx_params.svh"

module rx_core_tb;

   localparam int MAX_CASES = 16;

   logic        clk;
   logic        rst;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic [13:0] i_adc_a;
   logic [13:0] i_adc_b;
   logic [15:0] i_io_rx;
   logic        i_run;
   logic [31:0] o_sample;
   logic        o_valid;
   logic        i_ready;
   logic        o_overflow;

   // one row per case from the data file
   logic [127:0] names [MAX_CASES];
   int           gain_i [MAX_CASES], gain_q [MAX_CASES];
   int           rate [MAX_CASES], shift [MAX_CASES];
   int           mux_i [MAX_CASES], mux_q [MAX_CASES], gpio_ena [MAX_CASES];
   logic [15:0]  io_rx [MAX_CASES];
   int           adc_a [MAX_CASES], adc_b [MAX_CASES];
   int           cnt [MAX_CASES], mode [MAX_CASES];
   logic [31:0]  expd [MAX_CASES];
   int           n_cases;
   int           mismatches;
   int           other_errs;
   int           cycles;
   int           limit;

   rx_core rx_core_inst (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // run guard with the limit set once the cases are known
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit)
      begin
         $display("ERROR: run did not finish within %0d cycles", limit);
         $display("errors: %0d mismatches, %0d other", mismatches, other_errs + 1);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic read_cases();
      int    fd;
      int    n;
      string line;
      fd = $fopen("tests/rx_cases.txt", "r");
      if (fd == 0)
      begin
         $display("ERROR: cannot open tests/rx_cases.txt");
         other_errs++;
         return;
      end
      while (!$feof(fd) && n_cases < MAX_CASES)
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 4 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %d %d %d %d %d %d %d %h %d %d %d %h %d",
                     names[n_cases], gain_i[n_cases], gain_q[n_cases], rate[n_cases],
                     shift[n_cases], mux_i[n_cases], mux_q[n_cases], gpio_ena[n_cases],
                     io_rx[n_cases], adc_a[n_cases], adc_b[n_cases], cnt[n_cases],
                     expd[n_cases], mode[n_cases]);
         if (n == 14)
            n_cases++;
         else
         begin
            $display("ERROR: malformed line in case file: %s", line);
            other_errs++;
         end
      end
      $fclose(fd);
   endtask

   task automatic write_reg(input int off, input logic [31:0] data);
      @(posedge clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= 8'(`RX_SET_BASE + off);
      i_set_data <= data;
   endtask

   // first word is skipped since it may hold samples from before the case
   task automatic check_words(input int c, input bit random_ready);
      int seen;
      seen = 0;
      while (seen < cnt[c] + 1)
      begin
         @(negedge clk);
         if (o_valid && i_ready)
         begin
            if (seen > 0)
               assert (o_sample == expd[c])
               else
               begin
                  mismatches++;
                  $display("Mismatch case %0s expected %h actual %h",
                           names[c], expd[c], o_sample);
               end
            seen++;
         end
         @(posedge clk);
         i_ready <= random_ready ? (($urandom % 10) < 7) : 1'b1;
      end
   endtask

   task automatic run_case(input int c);
      @(posedge clk);
      i_run   <= 1'b0;
      i_ready <= 1'b1;
      repeat (2) @(posedge clk);
      write_reg(`RX_REG_GAIN, {gain_i[c][15:0], gain_q[c][15:0]});
      write_reg(`RX_REG_RATE, 32'(rate[c]));
      write_reg(`RX_REG_SHIFT, 32'(shift[c]));
      write_reg(`RX_REG_MUX, 32'({mux_q[c][1:0], mux_i[c][1:0]}));
      write_reg(`RX_REG_GPIO, 32'(gpio_ena[c]));
      i_adc_a <= adc_a[c][13:0];
      i_adc_b <= adc_b[c][13:0];
      i_io_rx <= io_rx[c];
      @(posedge clk);
      i_set_stb <= 1'b0;
      @(posedge clk);
      i_run   <= 1'b1;
      i_ready <= (mode[c] == 0);
      if (mode[c] == 0)
         check_words(c, 1'b1);
      else
      begin
         repeat (12 * rate[c] + 20) @(posedge clk);
         @(negedge clk);
         assert (o_overflow)
         else
         begin
            other_errs++;
            $display("ERROR: case %0s overflow flag not set after long stall", names[c]);
         end
         @(posedge clk);
         i_ready <= 1'b1;
         check_words(c, 1'b0);
         @(posedge clk);
         i_run <= 1'b0;
         @(posedge clk);
         @(negedge clk);
         assert (!o_overflow && !o_valid)
         else
         begin
            other_errs++;
            $display("ERROR: case %0s overflow or valid still set after stop", names[c]);
         end
      end
   endtask

   initial
   begin
      void'($urandom(90499));
      rst        = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_adc_a    = '0;
      i_adc_b    = '0;
      i_io_rx    = '0;
      i_run      = 1'b0;
      i_ready    = 1'b0;
      mismatches = 0;
      other_errs = 0;
      cycles     = 0;
      limit      = 0;
      n_cases    = 0;
      read_cases();
      for (int c = 0; c < n_cases; c++)
         limit += 4 * (cnt[c] + 2) * rate[c];
      limit += 200;

      repeat (4) @(posedge clk);
      @(negedge clk);
      assert (!o_valid && !o_overflow)
      else
      begin
         other_errs++;
         $display("ERROR: valid or overflow high during reset");
      end
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      assert (!o_valid && !o_overflow)
      else
      begin
         other_errs++;
         $display("ERROR: valid or overflow high right after reset");
      end

      for (int c = 0; c < n_cases; c++)
         run_case(c);

      $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/rx_cases.txt */
# name gain_i gain_q rate shift mux_i mux_q gpio_ena io_rx(hex) adc_a adc_b count expected(hex) mode
# mode 0 = random ready, mode 1 = long stall then overflow check
mux_ab        1      1      1   0  0 1 0 0000  100   -200 4 0064ff38 0
mux_swap_neg  -3     2      1   0  1 0 0 0000  1000  50   4 ff6a07d0 0
mux_zero      5      5      1   0  0 3 0 0000  300   400  4 05dc0000 0
rate4_round   3      3      4   3  0 1 0 0000  13    -7   4 0014fff6 0
rate200_sh20  1000   -1000  200 20 0 0 0 0000  8000  8000 3 05f6fa0a 0
saturate      32767  -32768 8   0  0 0 0 0000  8191  0    4 7fff8000 0
gpio_bits     1      1      1   0  0 0 3 c000  4     0    4 00050005 0
backpressure  1      1      4   2  0 1 0 0000  100   -100 10 0064ff9c 1

/* rx_core.f */
+incdir+hdl
hdl/rx_pkg.sv
hdl/rx_stream_if.sv
hdl/rx_settings.sv
hdl/rx_decimator.sv
hdl/sample_fifo.sv
hdl/sample_packer.sv
hdl/rx_core.sv
tests/rx_core_sva.sv
tests/rx_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module rx_core_tb -f rx_core.f -o rx_core_sim

if ! ./obj_dir/rx_core_sim > sim.log 2>&1; then
   cat sim.log
   exit 1
fi
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
   exit 1
fi
exit 0
